//--- verilog/core_pkg.sv
// basic data types shared by datapath and memories
package core_pkg;

    //////////////////////////////
    // word types
    //////////////////////////////

    // data word, alu operands and register contents
    typedef logic [31:0] word_t;

    // instruction word, kept apart from data words
    typedef logic [31:0] instr_t;

    // register index, 32 architectural registers
    typedef logic [4:0] reg_idx_t;

    //////////////////////////////
    // memory sizes
    //////////////////////////////

    // default depths in words
    parameter int IMEM_DEPTH = 256;
    parameter int DMEM_DEPTH = 256;

    // word index width of the program load port
    parameter int LOAD_ADDR_W = 8;

endpackage

//--- verilog/isa_pkg.sv
// rv32i subset encodings and internal control codes
package isa_pkg;

    //////////////////////////////
    // major opcodes
    //////////////////////////////

    typedef enum logic [6:0] {
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111
    } opcode_t;

    // funct3 for alu ops
    parameter logic [2:0] F3_ADD = 3'b000;
    parameter logic [2:0] F3_AND = 3'b111;

    // funct3 for branches
    parameter logic [2:0] F3_BEQ = 3'b000;
    parameter logic [2:0] F3_BNE = 3'b001;
    parameter logic [2:0] F3_BLT = 3'b100;
    parameter logic [2:0] F3_BGE = 3'b101;

    // funct7 of register ops, alt selects sub
    parameter logic [6:0] F7_BASE = 7'b0000000;
    parameter logic [6:0] F7_ALT  = 7'b0100000;

    //////////////////////////////
    // internal codes
    //////////////////////////////

    // immediate layouts
    typedef enum logic [1:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_J
    } imm_fmt_t;

    // alu functions, compares return a flag in bit 0
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_EQ,
        ALU_NE,
        ALU_LT,
        ALU_GE
    } alu_op_t;

    // sequential pc step in bytes
    parameter logic [31:0] INSTR_BYTES = 32'd4;

endpackage

//--- verilog/word_ram.sv
`timescale 1ns/1ps

// word-indexed memory, shared by the instruction and data stores
// read is combinational, write lands on the rising edge
module word_ram #(
    parameter int  DEPTH   = core_pkg::DMEM_DEPTH,
    parameter type entry_t = core_pkg::word_t
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  entry_t                   wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output entry_t                   rdata
);

    // storage array, contents undefined until written
    entry_t mem [DEPTH];

    //////////////////////////////
    // write port
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    //////////////////////////////
    // read port
    //////////////////////////////

    // async read, same-cycle visibility for fetch and lw
    assign rdata = mem[raddr];

    // index must fall inside the array on every write
    a_waddr_in_range: assert property (
        @(posedge clk) we |-> (int'(waddr) < DEPTH)
    );

endmodule

//--- verilog/reg_file.sv
`timescale 1ns/1ps

// 32 x 32 register file
// two async read ports, one sync write port
module reg_file (
    input  logic               clk,
    input  logic               rst,
    input  logic               we,
    input  core_pkg::reg_idx_t rs1,
    input  core_pkg::reg_idx_t rs2,
    input  core_pkg::reg_idx_t rd,
    input  core_pkg::word_t    wdata,
    output core_pkg::word_t    rdata1,
    output core_pkg::word_t    rdata2
);

    core_pkg::word_t regs [32];

    //////////////////////////////
    // write port
    //////////////////////////////

    // reset clears every register
    // writes aimed at x0 are dropped
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != '0)) begin
            regs[rd] <= wdata;
        end
    end

    //////////////////////////////
    // read ports
    //////////////////////////////

    // x0 forced to zero on both ports
    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

    // stored x0 never drifts from zero across the run
    a_x0_zero: assert property (
        @(posedge clk) disable iff (rst) regs[0] == '0
    );

endmodule

//--- verilog/alu.sv
`timescale 1ns/1ps

// integer alu, also resolves branch compares
module alu (
    input  isa_pkg::alu_op_t op,
    input  core_pkg::word_t  a,
    input  core_pkg::word_t  b,
    output core_pkg::word_t  result
);

    // single compare outcome, packed into bit 0 below
    logic flag;

    always_comb begin
        flag   = 1'b0;
        result = '0;
        case (op)
            // arithmetic and logic
            isa_pkg::ALU_ADD: result = a + b;
            isa_pkg::ALU_SUB: result = a - b;
            isa_pkg::ALU_AND: result = a & b;
            // compares, result is 0 or 1
            isa_pkg::ALU_EQ: begin
                flag   = (a == b);
                result = {31'b0, flag};
            end
            isa_pkg::ALU_NE: begin
                flag   = (a != b);
                result = {31'b0, flag};
            end
            // signed less-than for blt
            isa_pkg::ALU_LT: begin
                flag   = ($signed(a) < $signed(b));
                result = {31'b0, flag};
            end
            // signed greater-or-equal for bge
            isa_pkg::ALU_GE: begin
                flag   = ($signed(a) >= $signed(b));
                result = {31'b0, flag};
            end
            default: result = '0;
        endcase
    end

endmodule

//--- verilog/decoder.sv
`timescale 1ns/1ps

// instruction decode, control lines plus immediate
module decoder (
    input  core_pkg::instr_t   instr,
    output core_pkg::reg_idx_t rs1,
    output core_pkg::reg_idx_t rs2,
    output core_pkg::reg_idx_t rd,
    output isa_pkg::alu_op_t   alu_op,
    output logic               alu_src_imm,
    output logic               reg_we,
    output logic               mem_we,
    output logic               wb_from_mem,
    output logic               pc_redirect,
    output core_pkg::word_t    imm
);

    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic [6:0]        funct7;
    isa_pkg::imm_fmt_t imm_fmt;

    //////////////////////////////
    // fixed fields
    //////////////////////////////

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // register fields sit in the same place for every format
    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    //////////////////////////////
    // control decode
    //////////////////////////////

    always_comb begin
        // defaults, nothing written, pc steps
        alu_op      = isa_pkg::ALU_ADD;
        alu_src_imm = 1'b0;
        reg_we      = 1'b0;
        mem_we      = 1'b0;
        wb_from_mem = 1'b0;
        pc_redirect = 1'b0;
        imm_fmt     = isa_pkg::IMM_I;
        case (opcode)
            isa_pkg::OP_IMM: begin
                alu_src_imm = 1'b1;
                if (funct3 == isa_pkg::F3_ADD) begin
                    reg_we = 1'b1;
                end else if (funct3 == isa_pkg::F3_AND) begin
                    alu_op = isa_pkg::ALU_AND;
                    reg_we = 1'b1;
                end
            end
            isa_pkg::OP_REG: begin
                // add, sub, and only
                if (funct7 == isa_pkg::F7_BASE && funct3 == isa_pkg::F3_ADD) begin
                    reg_we = 1'b1;
                end else if (funct7 == isa_pkg::F7_ALT && funct3 == isa_pkg::F3_ADD) begin
                    alu_op = isa_pkg::ALU_SUB;
                    reg_we = 1'b1;
                end else if (funct7 == isa_pkg::F7_BASE && funct3 == isa_pkg::F3_AND) begin
                    alu_op = isa_pkg::ALU_AND;
                    reg_we = 1'b1;
                end
            end
            // lw, address is rs1 + imm
            isa_pkg::OP_LOAD: begin
                alu_src_imm = 1'b1;
                reg_we      = 1'b1;
                wb_from_mem = 1'b1;
            end
            // sw, store data comes from rs2
            isa_pkg::OP_STORE: begin
                alu_src_imm = 1'b1;
                mem_we      = 1'b1;
                imm_fmt     = isa_pkg::IMM_S;
            end
            isa_pkg::OP_BRANCH: begin
                imm_fmt     = isa_pkg::IMM_B;
                pc_redirect = 1'b1;
                case (funct3)
                    isa_pkg::F3_BEQ: alu_op = isa_pkg::ALU_EQ;
                    isa_pkg::F3_BNE: alu_op = isa_pkg::ALU_NE;
                    isa_pkg::F3_BLT: alu_op = isa_pkg::ALU_LT;
                    isa_pkg::F3_BGE: alu_op = isa_pkg::ALU_GE;
                    // unsupported compare, never taken
                    default: pc_redirect = 1'b0;
                endcase
            end
            // jal, no link write in this core
            isa_pkg::OP_JAL: begin
                imm_fmt     = isa_pkg::IMM_J;
                pc_redirect = 1'b1;
            end
            default: begin
            end
        endcase
    end

    //////////////////////////////
    // immediate generation
    //////////////////////////////

    always_comb begin
        case (imm_fmt)
            isa_pkg::IMM_S: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            // branch offsets are even, bit 0 implied
            isa_pkg::IMM_B: imm = {{20{instr[31]}}, instr[7], instr[30:25],
                                   instr[11:8], 1'b0};
            isa_pkg::IMM_J: imm = {{12{instr[31]}}, instr[19:12], instr[20],
                                   instr[30:21], 1'b0};
            default:        imm = {{20{instr[31]}}, instr[31:20]};
        endcase
    end

    // a single instruction targets either the register file or memory
    always_comb begin
        a_one_write_target: assert (!(reg_we && mem_we));
    end

endmodule

//--- verilog/program_counter.sv
`timescale 1ns/1ps

// pc register, byte address
module program_counter (
    input  logic            clk,
    input  logic            rst,
    input  logic            take_offset,
    input  core_pkg::word_t offset,
    output core_pkg::word_t pc
);

    // next pc, relative jump or sequential step
    core_pkg::word_t pc_next;

    assign pc_next = take_offset ? (pc + offset) : (pc + isa_pkg::INSTR_BYTES);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= pc_next;
        end
    end

    // fetch drops pc[1:0], so they must stay clear
    a_pc_aligned: assert property (
        @(posedge clk) disable iff (rst) pc[1:0] == 2'b00
    );

endmodule

//--- verilog/cpu_core.sv
`timescale 1ns/1ps

// single-cycle rv32i subset core
// fetch, decode, execute, memory and writeback in one clock
module cpu_core #(
    parameter int IMEM_DEPTH = core_pkg::IMEM_DEPTH,
    parameter int DMEM_DEPTH = core_pkg::DMEM_DEPTH
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            load_we,
    input  logic [core_pkg::LOAD_ADDR_W-1:0] load_addr,
    input  core_pkg::instr_t                load_data,
    output core_pkg::word_t                 pc,
    output core_pkg::instr_t                instr,
    output logic                            wb_valid,
    output core_pkg::reg_idx_t              wb_rd,
    output core_pkg::word_t                 wb_data,
    output logic                            store_valid,
    output core_pkg::word_t                 store_addr,
    output core_pkg::word_t                 store_data
);

    localparam int IMEM_AW = $clog2(IMEM_DEPTH);
    localparam int DMEM_AW = $clog2(DMEM_DEPTH);

    core_pkg::reg_idx_t rs1;
    core_pkg::reg_idx_t rs2;
    core_pkg::reg_idx_t rd;
    isa_pkg::alu_op_t   alu_op;
    logic               alu_src_imm;
    logic               reg_we;
    logic               mem_we;
    logic               wb_from_mem;
    logic               pc_redirect;
    logic               is_jal;
    logic               take_offset;
    core_pkg::word_t    imm;
    core_pkg::word_t    rdata1;
    core_pkg::word_t    rdata2;
    core_pkg::word_t    alu_b;
    core_pkg::word_t    alu_result;
    core_pkg::word_t    mem_rdata;
    core_pkg::word_t    reg_wdata;

    //////////////////////////////
    // fetch
    //////////////////////////////

    program_counter u_pc (
        .clk        (clk),
        .rst        (rst),
        .take_offset(take_offset),
        .offset     (imm),
        .pc         (pc)
    );

    // program loads only while held in reset
    word_ram #(.DEPTH(IMEM_DEPTH), .entry_t(core_pkg::instr_t)) imem (
        .clk  (clk),
        .we   (load_we & rst),
        .waddr(IMEM_AW'(load_addr)),
        .wdata(load_data),
        .raddr(pc[IMEM_AW+1:2]),
        .rdata(instr)
    );

    //////////////////////////////
    // decode and execute
    //////////////////////////////

    decoder u_dec (
        .instr      (instr),
        .rs1        (rs1),
        .rs2        (rs2),
        .rd         (rd),
        .alu_op     (alu_op),
        .alu_src_imm(alu_src_imm),
        .reg_we     (reg_we),
        .mem_we     (mem_we),
        .wb_from_mem(wb_from_mem),
        .pc_redirect(pc_redirect),
        .imm        (imm)
    );

    reg_file u_rf (
        .clk   (clk),
        .rst   (rst),
        .we    (reg_we),
        .rs1   (rs1),
        .rs2   (rs2),
        .rd    (rd),
        .wdata (reg_wdata),
        .rdata1(rdata1),
        .rdata2(rdata2)
    );

    // operand b, immediate or rs2
    assign alu_b = alu_src_imm ? imm : rdata2;

    alu u_alu (
        .op    (alu_op),
        .a     (rdata1),
        .b     (alu_b),
        .result(alu_result)
    );

    // jal always jumps, branches need the compare flag
    assign is_jal      = (instr[6:0] == isa_pkg::OP_JAL);
    assign take_offset = pc_redirect & (is_jal | alu_result[0]);

    //////////////////////////////
    // memory and writeback
    //////////////////////////////

    // effective address used directly as word index
    word_ram #(.DEPTH(DMEM_DEPTH), .entry_t(core_pkg::word_t)) dmem (
        .clk  (clk),
        .we   (mem_we & ~rst),
        .waddr(alu_result[DMEM_AW-1:0]),
        .wdata(rdata2),
        .raddr(alu_result[DMEM_AW-1:0]),
        .rdata(mem_rdata)
    );

    assign reg_wdata = wb_from_mem ? mem_rdata : alu_result;

    // trace taps, quiet while in reset
    assign wb_valid    = reg_we & ~rst;
    assign wb_rd       = rd;
    assign wb_data     = reg_wdata;
    assign store_valid = mem_we & ~rst;
    assign store_addr  = alu_result;
    assign store_data  = rdata2;

endmodule

//--- tb/tb_clock.sv
`timescale 1ns/1ps

// free-running 10 ns clock plus power-on reset
module tb_clock #(
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // release just after a rising edge, like every other tb input
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
    end

endmodule

//--- tb/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;

    localparam int IMEM_DEPTH = 256;
    localparam int DMEM_DEPTH = 256;
    localparam int LOAD_W     = core_pkg::LOAD_ADDR_W;

    // tests file image of 512 words
    localparam int TESTS_AW    = 9;
    localparam int TESTS_WORDS = 1 << TESTS_AW;

    // cycle limits for every wait
    localparam int RESET_TIMEOUT    = 20;
    localparam int RUN_TIMEOUT      = 2000;
    localparam int HALT_HOLD_CYCLES = 3;

    // jal x0 with offset 0 parks the pc
    localparam logic [31:0] HALT_INSTR = 32'h0000_006f;
    // header mode 1 compares only the final stores
    localparam logic [31:0] MODE_TAIL  = 32'd1;

    logic               clk;
    logic               por_rst;
    logic               hold_rst;
    logic               rst;
    logic               load_we;
    logic [LOAD_W-1:0]  load_addr;
    core_pkg::instr_t   load_data;
    core_pkg::word_t    pc;
    core_pkg::instr_t   instr;
    logic               wb_valid;
    core_pkg::reg_idx_t wb_rd;
    core_pkg::word_t    wb_data;
    logic               store_valid;
    core_pkg::word_t    store_addr;
    core_pkg::word_t    store_data;

    logic [31:0] tests_mem [TESTS_WORDS];

    tb_clock #(.RESET_CYCLES(3)) u_clock (
        .clk(clk),
        .rst(por_rst)
    );

    // core stays in reset while a program is loaded
    assign rst = por_rst | hold_rst;

    cpu_core #(.IMEM_DEPTH(IMEM_DEPTH), .DMEM_DEPTH(DMEM_DEPTH)) UUT (
        .clk        (clk),
        .rst        (rst),
        .load_we    (load_we),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .pc         (pc),
        .instr      (instr),
        .wb_valid   (wb_valid),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .store_valid(store_valid),
        .store_addr (store_addr),
        .store_data (store_data)
    );

    //////////////////////////////
    // helpers
    //////////////////////////////

    function automatic logic [31:0] test_word(input int idx);
        return tests_mem[idx[TESTS_AW-1:0]];
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic abort_run(input string reason);
        $display("%s, at %0t ns", reason, $time);
        $display("=== FAIL ===");
        $fatal(1, "run aborted");
    endtask

    // pc parked at 0 with no trace events
    task automatic check_reset_state();
        check_value(pc, 32'h0, "pc in reset");
        check_value({31'b0, wb_valid}, 32'h0, "wb_valid in reset");
        check_value({31'b0, store_valid}, 32'h0, "store_valid in reset");
    endtask

    task automatic wait_power_on_reset();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            check_reset_state();
            cycles++;
            if (cycles > RESET_TIMEOUT) begin
                abort_run("power-on reset was never released");
            end
        end while (por_rst);
    endtask

    //////////////////////////////
    // program load and run
    //////////////////////////////

    // one word per cycle through the load port with reset held
    task automatic load_program(input int base, input int nwords);
        @(posedge clk);
        #1;
        hold_rst = 1'b1;
        for (int k = 0; k < nwords; k++) begin
            load_we   = 1'b1;
            load_addr = LOAD_W'(k);
            load_data = test_word(base + k);
            @(negedge clk);
            check_reset_state();
            @(posedge clk);
            #1;
        end
        // last word lands on that edge so reset can drop
        load_we  = 1'b0;
        hold_rst = 1'b0;
    endtask

    // samples the trace mid-cycle until the halt instruction shows up
    task automatic run_program(input int wb_base, input int nwb, input int st_base,
                               input int nst, input logic [31:0] mode);
        int          cycles;
        int          wb_seen;
        int          st_seen;
        int          first;
        logic        halted;
        logic [31:0] st_addr_q [$];
        logic [31:0] st_data_q [$];
        cycles  = 0;
        wb_seen = 0;
        st_seen = 0;
        halted  = 1'b0;
        while (!halted) begin
            @(negedge clk);
            if (instr == HALT_INSTR) begin
                halted = 1'b1;
            end else begin
                if (wb_valid && mode != MODE_TAIL) begin
                    if (wb_seen >= nwb) begin
                        abort_run("unexpected extra writeback event");
                    end else begin
                        check_value({27'b0, wb_rd}, test_word(wb_base + 2 * wb_seen), "wb_rd");
                        check_value(wb_data, test_word(wb_base + 2 * wb_seen + 1), "wb_data");
                    end
                end
                if (wb_valid) begin
                    wb_seen++;
                end
                if (store_valid && mode != MODE_TAIL) begin
                    if (st_seen >= nst) begin
                        abort_run("unexpected extra store event");
                    end else begin
                        check_value(store_addr, test_word(st_base + 2 * st_seen), "store_addr");
                        check_value(store_data, test_word(st_base + 2 * st_seen + 1),
                                    "store_data");
                    end
                end
                if (store_valid) begin
                    st_addr_q.push_back(store_addr);
                    st_data_q.push_back(store_data);
                    st_seen++;
                end
            end
            cycles++;
            if (!halted && cycles > RUN_TIMEOUT) begin
                abort_run("program did not reach the halt instruction in time");
            end
        end
        // trace must be complete by the time the core parks
        if (mode == MODE_TAIL) begin
            if (st_addr_q.size() < nst) begin
                abort_run("fewer stores seen than the final trace expects");
            end else begin
                first = st_addr_q.size() - nst;
                for (int j = 0; j < nst; j++) begin
                    check_value(st_addr_q[first + j], test_word(st_base + 2 * j),
                                "final store_addr");
                    check_value(st_data_q[first + j], test_word(st_base + 2 * j + 1),
                                "final store_data");
                end
            end
        end else if (wb_seen != nwb) begin
            abort_run("writeback events missing at halt");
        end else if (st_seen != nst) begin
            abort_run("store events missing at halt");
        end
    endtask

    // halt jal must keep the pc fixed and stay silent
    task automatic check_halt_hold(input core_pkg::word_t halt_pc);
        check_value(pc, halt_pc, "pc at halt");
        for (int c = 0; c < HALT_HOLD_CYCLES; c++) begin
            @(negedge clk);
            check_value(pc, halt_pc, "pc while halted");
            check_value({31'b0, wb_valid}, 32'h0, "wb_valid while halted");
            check_value({31'b0, store_valid}, 32'h0, "store_valid while halted");
        end
    endtask

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial begin
        int          ptr;
        int          nwords;
        int          nwb;
        int          nst;
        int          wb_base;
        int          st_base;
        int          next_ptr;
        int          ntests;
        logic [31:0] mode;
        load_we   = 1'b0;
        load_addr = '0;
        load_data = '0;
        hold_rst  = 1'b1;
        ptr       = 0;
        ntests    = 0;
        $readmemh("tb/cpu_tests.txt", tests_mem);
        wait_power_on_reset();
        // header of zeros ends the list
        while (test_word(ptr) != 32'h0) begin
            nwords   = int'(test_word(ptr));
            nwb      = int'(test_word(ptr + 1));
            nst      = int'(test_word(ptr + 2));
            mode     = test_word(ptr + 3);
            wb_base  = ptr + 4 + nwords;
            st_base  = wb_base + 2 * nwb;
            next_ptr = st_base + 2 * nst;
            if (next_ptr + 4 > TESTS_WORDS) begin
                abort_run("test record runs past the end of the tests file");
            end else if (nwords > IMEM_DEPTH) begin
                abort_run("program does not fit the instruction memory");
            end else if (test_word(ptr + 3 + nwords) !== HALT_INSTR) begin
                abort_run("program does not end with the halt instruction");
            end else begin
                load_program(ptr + 4, nwords);
                run_program(wb_base, nwb, st_base, nst, mode);
                // halt sits in the last program word
                check_halt_hold(32'(4 * (nwords - 1)));
                ntests++;
                $display("test %0d done at %0t ns", ntests, $time);
                ptr = next_ptr;
            end
        end
        if (ntests == 0) begin
            abort_run("no tests were read from tb/cpu_tests.txt");
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

//--- files.f
verilog/core_pkg.sv
verilog/isa_pkg.sv
verilog/word_ram.sv
verilog/reg_file.sv
verilog/alu.sv
verilog/decoder.sv
verilog/program_counter.sv
verilog/cpu_core.sv
tb/tb_clock.sv
tb/tb_cpu.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert \
    --top-module tb_cpu \
    -f files.f \
    -o tb_cpu_sim
./obj_dir/tb_cpu_sim

//--- tb/cpu_tests.txt
// header: program words, writeback events, store events, mode (0 full trace, 1 final stores)
// then program words, writeback pairs (rd data), store pairs (byte address data)
// a header of zeros ends the list

// alu ops, negative immediates, write to x0 then read of x0
0000000A 00000009 00000000 00000000
00500093 FFD00113 002081B3 40208233 0020F2B3
0F017313 00708013 001003B3 FFF17413 0000006F
00000001 00000005  00000002 FFFFFFFD  00000003 00000002
00000004 00000008  00000005 00000005  00000006 000000F0
00000000 0000000C  00000007 00000005  00000008 FFFFFFFD

// sw to three word addresses, lw back
0000000A 00000006 00000003 00000000
01100093 02200113 00800193 00102023 0021A223
FE31AFA3 00002203 0041A283 FFF1A303 0000006F
00000001 00000011  00000002 00000022  00000003 00000008
00000004 00000011  00000005 00000022  00000006 00000008
00000000 00000011  0000000C 00000022  00000007 00000008

// beq bne blt bge, taken and not taken, x1 = -2, x2 = x3 = 3
00000016 00000007 00000000 00000000
FFE00093 00300113 00300193 00310463 00100513 00208463
00200593 00209463 00300613 00311463 00400693 0020C463
00500713 00114463 00600793 00115463 00700813 0020D463
00800893 00315463 00900913 0000006F
00000001 FFFFFFFE  00000002 00000003  00000003 00000003
0000000B 00000002  0000000D 00000004  0000000F 00000006
00000011 00000008

// forward and backward jal
00000007 00000003 00000000 00000000
00100093 00C0006F 00200113 00C0006F 00300193 FF5FF06F 0000006F
00000001 00000001  00000003 00000003  00000002 00000002

// insertion sort of 7 -3 12 0, sorted copy stored at 16..28
0000001E 00000000 00000004 00000001
00700093 00102023 FFD00093 00102223 00C00093 00102423
00002623 01000493 00400113 02915863 00012183 FFC10213
00024C63 00022283 0051D863 00522223 FFC20213 FEDFF06F
00322223 00410113 FD5FF06F 00002283 00502823 00402283
00502A23 00802283 00502C23 00C02283 00502E23 0000006F
00000010 FFFFFFFD  00000014 00000000  00000018 00000007  0000001C 0000000C

00000000 00000000 00000000 00000000
